// File: hdl/pad_pkg.sv
// Shared widths, counts and types for the console pad port logic
// Pad word layout constants used by mapper, tracker and sequencer
package pad_pkg;

	// ======================================================================
	// Widths and counts
	// ======================================================================
	localparam int HOST_JOY_W    = 32; // One host joystick word
	localparam int NUM_PORTS     = 5;  // Multitap ports with a real pad
	localparam int PORT_IDX_W    = 3;  // Port index, counts 0 to 7
	localparam int PAD_W         = 12; // Three nibbles per pad word
	localparam int NIBBLE_W      = 4;  // Console return nibble

	// Mouse side
	localparam int MOUSE_POS_W   = 9;  // Host motion words
	localparam int MOUSE_DELTA_W = 8;  // Delta bytes sent to the console
	localparam int MOUSE_FLAGS_W = 8;  // Host mouse flag byte
	localparam int MOUSE_TO_W    = 15; // Inactivity timeout, saturating
	localparam int MOUSE_STEP_W  = 2;  // Four position nibbles

	// Console pad outputs, SEL and CLR
	localparam int JOY_OUT_W     = 2;
	localparam int SEL_BIT       = 0;
	localparam int CLR_BIT       = 1;

	// ======================================================================
	// Types
	// ======================================================================
	typedef logic [PAD_W-1:0]      pad_word_t;
	typedef pad_word_t [NUM_PORTS-1:0] pad_bank_t;
	typedef logic [PORT_IDX_W-1:0] port_idx_t;
	typedef logic [NIBBLE_W-1:0]   nibble_t;

	// ======================================================================
	// Pad word constants
	// ======================================================================
	// Pad word is active low
	//   [3:0]   run, select, II, I
	//   [7:4]   left, down, right, up
	//   [11:8]  VI, V, IV, III
	localparam pad_word_t IDLE_PAD = '1; // Ports 5 to 7, nothing pressed

	// Fourth nibble on a pad, zero flags a six button pad in the high bank
	localparam nibble_t PAD_TAG = '0;

	// Port with the mouse in place of a pad
	localparam port_idx_t MOUSE_PORT = '0;

endpackage

// File: hdl/pad_mapper.sv
// Host joystick registers and console pad remap
// Joystick swap for the first two pads, five active low pad words out

`timescale 1ns/1ps

module pad_mapper (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [pad_pkg::HOST_JOY_W-1:0] joy_a,
	input  logic [pad_pkg::HOST_JOY_W-1:0] joy_b,
	input  logic [pad_pkg::HOST_JOY_W-1:0] joy_2,
	input  logic [pad_pkg::HOST_JOY_W-1:0] joy_3,
	input  logic [pad_pkg::HOST_JOY_W-1:0] joy_4,
	input  logic                           joy_swap,
	output pad_pkg::pad_bank_t             pad_words
);

	// Host word in order of the multitap ports
	logic [pad_pkg::HOST_JOY_W-1:0] host_joy [pad_pkg::NUM_PORTS];

	// ======================================================================
	// Host to console bit order
	// ======================================================================
	// Host bits: 0 right, 1 left, 2 down, 3 up, 4 I, 5 II, 6 select, 7 run,
	// 8 to 11 buttons III to VI
	function automatic pad_pkg::pad_word_t remap_pad(
		input logic [pad_pkg::HOST_JOY_W-1:0] joy
	);
		pad_pkg::pad_word_t word;
		word[3:0]  = joy[7:4];                         // Run, select, II, I
		word[7:4]  = {joy[1], joy[2], joy[0], joy[3]}; // Left, down, right, up
		word[11:8] = joy[11:8];                        // VI to III
		return ~word;                                  // Console reads 0 as pressed
	endfunction

	// Swap only touches the first two pads
	always_comb begin
		host_joy[0] = joy_swap ? joy_b : joy_a;
		host_joy[1] = joy_swap ? joy_a : joy_b;
		host_joy[2] = joy_2;
		host_joy[3] = joy_3;
		host_joy[4] = joy_4;
	end

	// ======================================================================
	// Pad word registers
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < pad_pkg::NUM_PORTS; i++) begin
				pad_words[i] <= pad_pkg::IDLE_PAD;
			end
		end else begin
			for (int i = 0; i < pad_pkg::NUM_PORTS; i++) begin
				pad_words[i] <= remap_pad(host_joy[i]);
			end
		end
	end

endmodule

// File: hdl/mouse_tracker.sv
// Mouse emulation for console port 0
// Pending and visible delta bytes, four nibble step counter
// Inactivity timeout that rewinds the transfer

`timescale 1ns/1ps

module mouse_tracker (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic [pad_pkg::MOUSE_POS_W-1:0] mouse_x,
	input  logic [pad_pkg::MOUSE_POS_W-1:0] mouse_y,
	input  logic                            mouse_strobe,
	input  logic                            clr,
	input  logic                            clr_rise,
	output pad_pkg::nibble_t                mouse_nibble
);

	// Deltas collected since the last transfer
	logic [pad_pkg::MOUSE_DELTA_W-1:0] pend_x;
	logic [pad_pkg::MOUSE_DELTA_W-1:0] pend_y;

	// Deltas being shifted out to the console
	logic [pad_pkg::MOUSE_DELTA_W-1:0] vis_x;
	logic [pad_pkg::MOUSE_DELTA_W-1:0] vis_y;

	logic [pad_pkg::MOUSE_STEP_W-1:0] step;
	logic [pad_pkg::MOUSE_TO_W-1:0]   mouse_to;
	logic                             to_full;

	assign to_full = &mouse_to;

	// ======================================================================
	// Timeout counter
	// ======================================================================
	// Clears while CLR is high, counts up and sticks at all ones otherwise
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mouse_to <= '0;
		end else if (clr) begin
			mouse_to <= '0;
		end else if (!to_full) begin
			mouse_to <= mouse_to + 1'b1;
		end
	end

	// ======================================================================
	// Step counter and delta registers
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			step   <= '1;
			pend_x <= '0;
			pend_y <= '0;
			vis_x  <= '0;
			vis_y  <= '0;
		end else begin
			// Idle console, next CLR rise starts at step 0
			if (to_full) step <= '1;

			if (clr_rise) begin
				step <= step + 1'b1;
				if (&step) begin
					// Hand the collected motion over for this transfer
					vis_x  <= pend_x;
					vis_y  <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// A new host report wins over the clear above
			if (mouse_strobe) begin
				pend_x <= pad_pkg::MOUSE_DELTA_W'(0) - mouse_x[pad_pkg::MOUSE_DELTA_W-1:0];
				pend_y <= mouse_y[pad_pkg::MOUSE_DELTA_W-1:0];
			end
		end
	end

	// Nibble shown for the current step
	always_comb begin
		case (step)
			2'd0:    mouse_nibble = vis_x[7:4];
			2'd1:    mouse_nibble = vis_x[3:0];
			2'd2:    mouse_nibble = vis_y[7:4];
			default: mouse_nibble = vis_y[3:0];
		endcase
	end

	// Saturation holds and the step stays parked for as long as CLR stays low
	a_to_no_wrap: assert property (
		@(posedge clk_sys) disable iff (reset)
		(!clr && to_full) |=> (to_full && &step)
	) else $error("mouse_to wrapped or step moved while clr low, mouse_to=%h step=%h",
		mouse_to, step);

endmodule

// File: hdl/pad_sequencer.sv
// Console pad port sequencer
// SEL and CLR edge detection, multitap port index, six button bank
// Selects mouse byte, pad word or idle pad and latches the return nibble

`timescale 1ns/1ps

module pad_sequencer (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic [pad_pkg::JOY_OUT_W-1:0] joy_out,
	input  logic                          turbotap,
	input  logic                          buttons6,
	input  logic                          mouse_en,
	input  logic [1:0]                    mouse_btn,
	input  pad_pkg::pad_bank_t            pad_words,
	input  pad_pkg::nibble_t              mouse_nibble,
	output logic                          clr_rise,
	output pad_pkg::nibble_t              joy_in
);

	logic [pad_pkg::JOY_OUT_W-1:0] last_out;
	logic                          sel;
	logic                          clr;
	logic                          sel_rise;

	pad_pkg::port_idx_t port_idx;
	logic               high_bank;

	logic [2*pad_pkg::NIBBLE_W-1:0] mouse_byte;
	logic [4*pad_pkg::NIBBLE_W-1:0] port_data; // Four nibbles of the current port
	logic [1:0]                     nib_sel;

	// ======================================================================
	// Edge detection on the console outputs
	// ======================================================================
	assign sel = joy_out[pad_pkg::SEL_BIT];
	assign clr = joy_out[pad_pkg::CLR_BIT];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_out <= '0;
		end else begin
			last_out <= joy_out;
		end
	end

	assign sel_rise = sel & ~last_out[pad_pkg::SEL_BIT];
	assign clr_rise = clr & ~last_out[pad_pkg::CLR_BIT];

	// ======================================================================
	// Port data selection
	// ======================================================================
	// Mouse low nibble is run and select of pad 0 plus the two buttons
	assign mouse_byte = {mouse_nibble,
		pad_words[0][3:2], ~mouse_btn[0], ~mouse_btn[1]};

	always_comb begin
		if (port_idx == pad_pkg::MOUSE_PORT && mouse_en) begin
			port_data = {mouse_byte, mouse_byte}; // Same byte in both banks
		end else if (port_idx < pad_pkg::PORT_IDX_W'(pad_pkg::NUM_PORTS)) begin
			port_data = {pad_pkg::PAD_TAG, pad_words[port_idx]};
		end else begin
			port_data = {pad_pkg::PAD_TAG, pad_pkg::IDLE_PAD};
		end
	end

	// Bank picks the pair, SEL picks within it
	assign nib_sel = {high_bank, sel};

	// ======================================================================
	// Port index, bank and return latch
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_idx  <= '0;
			high_bank <= 1'b0;
			joy_in    <= '0;
		end else begin
			joy_in <= port_data[{nib_sel, 2'b00} +: pad_pkg::NIBBLE_W];

			if (clr) begin
				// CLR restarts the scan and blanks the port
				port_idx <= '0;
				joy_in   <= '0;
				if (clr_rise) high_bank <= ~high_bank & buttons6;
			end else if (sel_rise && turbotap) begin
				port_idx <= port_idx + 1'b1; // Next multitap port
			end
		end
	end

	// CLR blanks the return and rewinds the multitap scan together
	a_clr_blank: assert property (
		@(posedge clk_sys) disable iff (reset)
		clr |=> (joy_in == '0 && port_idx == '0)
	) else $error("CLR not honoured, joy_in=%h port_idx=%h", joy_in, port_idx);

endmodule

// File: hdl/pce_input_top.sv
// Console controller port top level
// Pad mapper and mouse tracker feed the pad sequencer

`timescale 1ns/1ps

module pce_input_top (
	input  logic                              clk_sys,
	input  logic                              reset,

	// Host pads
	input  logic [pad_pkg::HOST_JOY_W-1:0]    joy_a,
	input  logic [pad_pkg::HOST_JOY_W-1:0]    joy_b,
	input  logic [pad_pkg::HOST_JOY_W-1:0]    joy_2,
	input  logic [pad_pkg::HOST_JOY_W-1:0]    joy_3,
	input  logic [pad_pkg::HOST_JOY_W-1:0]    joy_4,

	// Host mouse
	input  logic [pad_pkg::MOUSE_POS_W-1:0]   mouse_x,
	input  logic [pad_pkg::MOUSE_POS_W-1:0]   mouse_y,
	input  logic [pad_pkg::MOUSE_FLAGS_W-1:0] mouse_flags, // Bit 0 left, bit 1 right
	input  logic                              mouse_strobe,

	// Options
	input  logic                              joy_swap,
	input  logic                              turbotap,
	input  logic                              buttons6,
	input  logic                              mouse_en,

	// Console pad port
	input  logic [pad_pkg::JOY_OUT_W-1:0]     joy_out, // SEL, CLR
	output pad_pkg::nibble_t                  joy_in
);

	pad_pkg::pad_bank_t pad_words;
	pad_pkg::nibble_t   mouse_nibble;
	logic               clr_rise;

	// ======================================================================
	// Pads and mouse
	// ======================================================================
	pad_mapper u_pad_mapper (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.joy_a     (joy_a),
		.joy_b     (joy_b),
		.joy_2     (joy_2),
		.joy_3     (joy_3),
		.joy_4     (joy_4),
		.joy_swap  (joy_swap),
		.pad_words (pad_words)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_strobe (mouse_strobe),
		.clr          (joy_out[pad_pkg::CLR_BIT]),
		.clr_rise     (clr_rise),
		.mouse_nibble (mouse_nibble)
	);

	// ======================================================================
	// Console side
	// ======================================================================
	pad_sequencer u_pad_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_out      (joy_out),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.mouse_btn    (mouse_flags[1:0]),
		.pad_words    (pad_words),
		.mouse_nibble (mouse_nibble),
		.clr_rise     (clr_rise),
		.joy_in       (joy_in)
	);

endmodule

// File: tests/tb_pce_input_model.svh
// Expected console nibbles from the pad port rules
// Pad remap, nibble choice, mouse position nibbles and mouse button nibble

`ifndef TB_PCE_INPUT_MODEL_SVH
`define TB_PCE_INPUT_MODEL_SVH

// Host bits 0 right, 1 left, 2 down, 3 up, 4 I, 5 II, 6 select, 7 run, 8 to 11 III to VI
function automatic pad_pkg::pad_word_t remap_host_pad(
	input logic [pad_pkg::HOST_JOY_W-1:0] joy
);
	pad_pkg::pad_word_t word;
	word[0] = ~joy[4]; // I
	word[1] = ~joy[5]; // II
	word[2] = ~joy[6]; // Select
	word[3] = ~joy[7]; // Run
	word[4] = ~joy[3]; // Up
	word[5] = ~joy[0]; // Right
	word[6] = ~joy[2]; // Down
	word[7] = ~joy[1]; // Left
	for (int b = 8; b < 12; b++) begin
		word[b] = ~joy[b]; // Buttons III to VI
	end
	return word;
endfunction

// Bank and SEL pick one of four nibbles with the six button tag last
function automatic pad_pkg::nibble_t select_pad_nibble(
	input pad_pkg::pad_word_t word,
	input logic               bank,
	input logic               sel
);
	pad_pkg::nibble_t result;
	case ({bank, sel})
		2'b00:   result = word[3:0];
		2'b01:   result = word[7:4];
		2'b10:   result = word[11:8];
		default: result = 4'h0;
	endcase
	return result;
endfunction

function automatic pad_pkg::nibble_t position_nibble(
	input logic [pad_pkg::MOUSE_POS_W-1:0]  x,
	input logic [pad_pkg::MOUSE_POS_W-1:0]  y,
	input logic [pad_pkg::MOUSE_STEP_W-1:0] step
);
	logic [7:0]       dx;
	logic [7:0]       dy;
	pad_pkg::nibble_t result;
	dx = ~x[7:0] + 8'd1; // Console counts x the other way
	dy = y[7:0];
	case (step)
		2'd0:    result = dx[7:4];
		2'd1:    result = dx[3:0];
		2'd2:    result = dy[7:4];
		default: result = dy[3:0];
	endcase
	return result;
endfunction

// Position on SEL high, run and select with left and right buttons on SEL low
function automatic pad_pkg::nibble_t mouse_port_nibble(
	input logic [pad_pkg::HOST_JOY_W-1:0]    joy,
	input logic [pad_pkg::MOUSE_FLAGS_W-1:0] flags,
	input pad_pkg::nibble_t                  position,
	input logic                              sel
);
	pad_pkg::nibble_t low;
	low = {~joy[7], ~joy[6], ~flags[0], ~flags[1]};
	return sel ? position : low;
endfunction

`endif

// File: tests/tb_pce_input.sv
// Testbench for the console pad port logic
// Clock, reset, pad and mouse stimulus, checking assertions

`timescale 1ns/1ps

module tb_pce_input;

	`include "tb_pce_input_model.svh"

	logic                              clk_sys;
	logic                              reset;
	logic [pad_pkg::HOST_JOY_W-1:0]    joy_a;
	logic [pad_pkg::HOST_JOY_W-1:0]    joy_b;
	logic [pad_pkg::HOST_JOY_W-1:0]    joy_2;
	logic [pad_pkg::HOST_JOY_W-1:0]    joy_3;
	logic [pad_pkg::HOST_JOY_W-1:0]    joy_4;
	logic [pad_pkg::MOUSE_POS_W-1:0]   mouse_x;
	logic [pad_pkg::MOUSE_POS_W-1:0]   mouse_y;
	logic [pad_pkg::MOUSE_FLAGS_W-1:0] mouse_flags;
	logic                              mouse_strobe;
	logic                              joy_swap;
	logic                              turbotap;
	logic                              buttons6;
	logic                              mouse_en;
	logic [pad_pkg::JOY_OUT_W-1:0]     joy_out;
	pad_pkg::nibble_t                  joy_in;

	// Reference state of the port
	integer                            seed;
	int                                m_port;
	logic                              m_bank;
	logic [pad_pkg::MOUSE_STEP_W-1:0]  m_step;
	logic [pad_pkg::MOUSE_POS_W-1:0]   pend_x;
	logic [pad_pkg::MOUSE_POS_W-1:0]   pend_y;
	logic [pad_pkg::MOUSE_POS_W-1:0]   vis_x;
	logic [pad_pkg::MOUSE_POS_W-1:0]   vis_y;
	pad_pkg::nibble_t                  exp_nibble;
	logic                              chk_pad;
	logic                              chk_mouse;

	pce_input_top u_pce_input_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.joy_a        (joy_a),
		.joy_b        (joy_b),
		.joy_2        (joy_2),
		.joy_3        (joy_3),
		.joy_4        (joy_4),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_flags  (mouse_flags),
		.mouse_strobe (mouse_strobe),
		.joy_swap     (joy_swap),
		.turbotap     (turbotap),
		.buttons6     (buttons6),
		.mouse_en     (mouse_en),
		.joy_out      (joy_out),
		.joy_in       (joy_in)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Checking
	// ======================================================================
	task automatic report_mismatch(input string name, input pad_pkg::nibble_t got,
		input pad_pkg::nibble_t want);
		$display("Error: %s = %h, expected %h", name, got, want);
		$display("TB FAILED");
		$fatal(1, "nibble mismatch");
	endtask

	a_reset_zero: assert property (@(posedge clk_sys) $fell(reset) |-> joy_in == 4'h0)
		else report_mismatch("joy_in", $sampled(joy_in), 4'h0);

	a_clr_zero: assert property (@(posedge clk_sys) disable iff (reset)
		joy_out[pad_pkg::CLR_BIT] |=> joy_in == 4'h0)
		else report_mismatch("joy_in", $sampled(joy_in), 4'h0);

	a_pad_nibble: assert property (@(posedge clk_sys) disable iff (reset)
		chk_pad |-> joy_in == exp_nibble)
		else report_mismatch("joy_in", $sampled(joy_in), $sampled(exp_nibble));

	a_mouse_nibble: assert property (@(posedge clk_sys) disable iff (reset)
		chk_mouse |-> joy_in == exp_nibble)
		else report_mismatch("joy_in", $sampled(joy_in), $sampled(exp_nibble));

	function automatic pad_pkg::nibble_t predict_joy_in();
		logic [pad_pkg::HOST_JOY_W-1:0] first;
		logic [pad_pkg::HOST_JOY_W-1:0] word;
		pad_pkg::nibble_t               result;
		first = joy_swap ? joy_b : joy_a;
		case (m_port)
			0:       word = first;
			1:       word = joy_swap ? joy_a : joy_b;
			2:       word = joy_2;
			3:       word = joy_3;
			4:       word = joy_4;
			default: word = '0; // Missing pad reads as nothing pressed
		endcase
		if (m_port == 0 && mouse_en) begin
			result = mouse_port_nibble(first, mouse_flags,
				position_nibble(vis_x, vis_y, m_step), joy_out[pad_pkg::SEL_BIT]);
		end else begin
			result = select_pad_nibble(remap_host_pad(word), m_bank,
				joy_out[pad_pkg::SEL_BIT]);
		end
		return result;
	endfunction

	// ======================================================================
	// Stimulus
	// ======================================================================
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
		#10;
	endtask

	task automatic check_now();
		exp_nibble = predict_joy_in();
		wait_cycles(3);
		chk_mouse = (m_port == 0 && mouse_en);
		chk_pad   = !(m_port == 0 && mouse_en);
		wait_cycles(1);
		chk_pad   = 1'b0;
		chk_mouse = 1'b0;
	endtask

	task automatic drive_sel(input logic level);
		if (level && !joy_out[pad_pkg::SEL_BIT] && turbotap) m_port = (m_port + 1) % 8;
		joy_out[pad_pkg::SEL_BIT] = level;
		check_now();
	endtask

	task automatic clr_pulse();
		joy_out[pad_pkg::CLR_BIT] = 1'b1;
		wait_cycles(2);
		joy_out[pad_pkg::CLR_BIT] = 1'b0;
		m_port = 0;
		m_bank = buttons6 & ~m_bank;
		if (m_step == 2'd3) begin
			vis_x  = pend_x; // Transfer starts with the latest motion
			vis_y  = pend_y;
			pend_x = '0;
			pend_y = '0;
		end
		m_step = m_step + 2'd1;
		check_now();
	endtask

	task automatic strobe_mouse(input logic [8:0] x, input logic [8:0] y);
		mouse_x      = x;
		mouse_y      = y;
		mouse_strobe = 1'b1;
		wait_cycles(1);
		mouse_strobe = 1'b0;
		pend_x       = x;
		pend_y       = y;
	endtask

	// Guard against a stuck run
	initial begin
		for (int i = 0; i < 40000; i++) begin
			@(posedge clk_sys);
		end
		$display("Timeout: run did not finish within 40000 cycles");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 89;
		reset = 1'b1;
		{joy_a, joy_b, joy_2, joy_3, joy_4} = '0;
		{mouse_x, mouse_y, mouse_flags, mouse_strobe} = '0;
		{joy_swap, turbotap, buttons6, mouse_en} = '0;
		joy_out = '0;
		m_port = 0;
		m_bank = 1'b0;
		m_step = 2'd3;
		{pend_x, pend_y, vis_x, vis_y} = '0;
		{exp_nibble, chk_pad, chk_mouse} = '0;
		wait_cycles(5);
		reset = 1'b0;

		clr_pulse();
		drive_sel(1'b1);
		drive_sel(1'b0);

		for (int i = 0; i < 8; i++) begin // Port 0 with swap on odd passes
			joy_a    = $random(seed);
			joy_b    = $random(seed);
			joy_swap = i[0];
			drive_sel(1'b0);
			drive_sel(1'b1);
		end
		drive_sel(1'b0);

		// ======================================================================
		// Multitap and six button bank
		// ======================================================================
		joy_2    = $random(seed);
		joy_3    = $random(seed);
		joy_4    = $random(seed);
		turbotap = 1'b1;
		clr_pulse();
		for (int p = 1; p < 8; p++) begin
			drive_sel(1'b1);
			drive_sel(1'b0);
		end
		turbotap = 1'b0;
		clr_pulse();
		drive_sel(1'b1);
		drive_sel(1'b0);

		buttons6 = 1'b1;
		for (int i = 0; i < 4; i++) begin
			joy_b = $random(seed);
			clr_pulse();
			drive_sel(1'b1);
			drive_sel(1'b0);
		end
		buttons6 = 1'b0;
		clr_pulse();

		// ======================================================================
		// Mouse on port 0
		// ======================================================================
		mouse_en    = 1'b1;
		mouse_flags = 8'($random(seed));
		strobe_mouse(9'($random(seed)), 9'($random(seed)));
		for (int i = 0; i < 4; i++) begin
			clr_pulse();
			drive_sel(1'b1);
			drive_sel(1'b0);
		end

		clr_pulse();
		strobe_mouse(9'($random(seed)), 9'($random(seed)));
		wait_cycles(32800); // CLR low past the saturating timeout
		m_step = 2'd3;
		for (int i = 0; i < 4; i++) begin
			clr_pulse();
			drive_sel(1'b1);
			drive_sel(1'b0);
		end

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: project.f
+incdir+tests
hdl/pad_pkg.sv
hdl/pad_mapper.sv
hdl/mouse_tracker.sv
hdl/pad_sequencer.sv
hdl/pce_input_top.sv
tests/tb_pce_input.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the pad port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_pce_input -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_pce_input > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation passed"
exit 0
